// ==== design/score_pkg.sv ====
package score_pkg;

	localparam int NUM_CELLS = 30;
	localparam int GROUND_W  = 2 * NUM_CELLS;
	localparam int POS_W     = 9;
	localparam int CELL_PX   = 4; // Screen pixels per ground cell

	typedef enum logic [1:0] {
		CELL_EMPTY = 2'd0,
		CELL_GOOD  = 2'd2,
		CELL_BAD   = 2'd3
	} cell_t;

	localparam int CNT_W   = 2;
	localparam int SCORE_W = 7;
	localparam int LIVES_W = 2;
	localparam int DIGIT_W = 4;

	localparam logic [SCORE_W-1:0] SCORE_MAX  = 7'd99;
	localparam logic [LIVES_W-1:0] LIVES_INIT = 2'd3;

	localparam int GLYPH_COLS = 3;
	localparam int GLYPH_ROWS = 5;
	localparam int GLYPH_W    = GLYPH_COLS * GLYPH_ROWS;
	localparam int MAP_W      = 2 * GLYPH_W; // Tens glyph in the low half

	// Bottom row first, col 0 in the LSB of each group
	localparam logic [GLYPH_W-1:0] FONT [10] = '{
		15'b111_101_101_101_111,
		15'b111_010_010_011_010,
		15'b111_001_111_100_111,
		15'b111_100_111_100_111,
		15'b100_100_111_101_101,
		15'b111_100_111_001_111,
		15'b111_101_111_001_111,
		15'b100_100_100_100_111,
		15'b111_101_111_101_111,
		15'b111_100_111_101_111
	};

	localparam int X_W = 8;
	localparam int Y_W = 7;

	localparam logic [X_W-1:0] SCORE_X     = 8'd121;
	localparam logic [Y_W-1:0] SCORE_Y     = 7'd60;
	localparam int             DIGIT_PITCH = 4;

	localparam int                 COLOR_W     = 3;
	localparam logic [COLOR_W-1:0] COLOR_INK   = 3'd3;
	localparam logic [COLOR_W-1:0] COLOR_BLANK = 3'd0;

	typedef enum logic [1:0] {
		PAINT_IDLE,
		PAINT_RUN,
		PAINT_DONE
	} paint_state_t;

endpackage

// ==== design/catch_detect.sv ====
`timescale 1ns/1ps

module catch_detect (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          update,
	input  logic [score_pkg::GROUND_W-1:0] ground,
	input  logic [score_pkg::POS_W-1:0]    mouse_position,
	output logic [score_pkg::CNT_W-1:0]    good_count,
	output logic [score_pkg::CNT_W-1:0]    bad_count,
	output logic                          catch_valid
);
	import score_pkg::*;

	logic [POS_W-1:0] zone;
	logic [CNT_W-1:0] good_next;
	logic [CNT_W-1:0] bad_next;

	always_comb begin
		zone = POS_W'(mouse_position / CELL_PX);
		if (zone > NUM_CELLS - 1) begin
			zone = POS_W'(NUM_CELLS - 1); // Right edge of the field
		end
	end

	// Window is zone-1 .. zone+1, cells outside the row simply drop out
	always_comb begin
		good_next = '0;
		bad_next = '0;
		for (int i = 0; i < NUM_CELLS; i++) begin
			if (i + 1 >= zone && i <= zone + 1) begin
				case (ground[GROUND_W - 1 - $bits(cell_t) * i -: $bits(cell_t)])
					CELL_GOOD:  good_next = good_next + 1'b1;
					CELL_BAD:   bad_next = bad_next + 1'b1;
					CELL_EMPTY: ;
					default:    ; // Code 1 counts as empty
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			catch_valid <= 1'b0;
		end else begin
			catch_valid <= update;
		end
	end

	always_ff @(posedge clk) begin
		if (update) begin
			good_count <= good_next;
			bad_count <= bad_next;
		end
	end

endmodule

// ==== design/score_tally.sv ====
`timescale 1ns/1ps

module score_tally (
	input  logic                         clk,
	input  logic                         reset,
	input  logic [score_pkg::CNT_W-1:0]   good_count,
	input  logic [score_pkg::CNT_W-1:0]   bad_count,
	input  logic                         catch_valid,
	output logic [score_pkg::SCORE_W-1:0] score,
	output logic [score_pkg::LIVES_W-1:0] lives,
	output logic                         finish_game
);
	import score_pkg::*;

	logic [SCORE_W:0] score_sum; // One spare bit ahead of the cap

	assign score_sum = score + good_count;
	assign finish_game = (lives == '0);

	always_ff @(posedge clk) begin
		if (!reset) begin
			score <= '0;
			lives <= LIVES_INIT;
		end else if (catch_valid && !finish_game) begin
			if (score_sum > SCORE_MAX) begin
				score <= SCORE_MAX;
			end else begin
				score <= score_sum[SCORE_W-1:0];
			end
			if (bad_count >= lives) begin
				lives <= '0;
			end else begin
				lives <= lives - bad_count;
			end
		end
	end

endmodule

// ==== design/digit_split.sv ====
`timescale 1ns/1ps

module digit_split (
	input  logic                         clk,
	input  logic                         reset,
	input  logic [score_pkg::SCORE_W-1:0] score,
	output logic [score_pkg::DIGIT_W-1:0] tens,
	output logic [score_pkg::DIGIT_W-1:0] ones
);
	import score_pkg::*;

	logic [DIGIT_W-1:0] tens_next;
	logic [SCORE_W-1:0] rem;

	always_comb begin
		tens_next = '0;
		for (int d = 1; d < 10; d++) begin
			if (score >= d * 10) begin
				tens_next = DIGIT_W'(d); // Highest multiple reached wins
			end
		end
		rem = score - SCORE_W'(tens_next * 10);
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			tens <= '0;
			ones <= '0;
		end else begin
			tens <= tens_next;
			ones <= rem[DIGIT_W-1:0];
		end
	end

endmodule

// ==== design/glyph_map.sv ====
`timescale 1ns/1ps

module glyph_map (
	input  logic                         clk,
	input  logic                         reset,
	input  logic [score_pkg::DIGIT_W-1:0] tens,
	input  logic [score_pkg::DIGIT_W-1:0] ones,
	output logic [score_pkg::MAP_W-1:0]   map
);
	import score_pkg::*;

	logic [GLYPH_W-1:0] tens_glyph;
	logic [GLYPH_W-1:0] ones_glyph;

	function automatic logic [GLYPH_W-1:0] lookup(input logic [DIGIT_W-1:0] digit);
		if (digit > 4'd9) begin
			return FONT[0]; // Out of range digits show as 0
		end
		return FONT[digit];
	endfunction

	assign tens_glyph = lookup(tens);
	assign ones_glyph = lookup(ones);

	always_ff @(posedge clk) begin
		if (!reset) begin
			map <= {FONT[0], FONT[0]};
		end else begin
			map <= {ones_glyph, tens_glyph};
		end
	end

endmodule

// ==== design/score_painter.sv ====
`timescale 1ns/1ps

module score_painter (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         draw,
	input  logic [score_pkg::MAP_W-1:0]   map,
	output logic [score_pkg::X_W-1:0]     x,
	output logic [score_pkg::Y_W-1:0]     y,
	output logic [score_pkg::COLOR_W-1:0] color,
	output logic                         plot,
	output logic                         finish_drawing
);
	import score_pkg::*;

	paint_state_t       state;
	logic [4:0]         idx;
	logic [MAP_W-1:0]   snap;
	logic               digit_sel;
	logic [3:0]         bit_idx;
	logic [2:0]         row;
	logic [1:0]         col;

	// Pixel position of the current index inside its glyph
	always_comb begin
		digit_sel = (idx >= GLYPH_W);
		bit_idx = digit_sel ? 4'(idx - GLYPH_W) : idx[3:0];
		row = 3'(bit_idx / GLYPH_COLS);
		col = 2'(bit_idx % GLYPH_COLS);
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= PAINT_IDLE;
			idx <= '0;
			plot <= 1'b0;
			finish_drawing <= 1'b0;
			x <= '0;
			y <= '0;
			color <= '0;
		end else begin
			plot <= 1'b0;
			finish_drawing <= 1'b0;
			case (state)
				PAINT_IDLE: begin
					idx <= '0;
					if (draw) begin
						state <= PAINT_RUN;
					end
				end
				PAINT_RUN: begin
					if (!draw) begin
						state <= PAINT_IDLE; // Aborted frame
					end else begin
						x <= X_W'(SCORE_X + digit_sel * DIGIT_PITCH + col);
						y <= Y_W'(SCORE_Y + row);
						color <= snap[idx] ? COLOR_INK : COLOR_BLANK;
						plot <= 1'b1;
						idx <= idx + 1'b1;
						if (idx == MAP_W - 1) begin
							state <= PAINT_DONE;
						end
					end
				end
				PAINT_DONE: begin
					finish_drawing <= draw;
					if (!draw) begin
						state <= PAINT_IDLE;
					end
				end
				default: state <= PAINT_IDLE;
			endcase
		end
	end

	// Frame is taken once so a score change cannot tear the digits
	always_ff @(posedge clk) begin
		if (state == PAINT_IDLE && draw) begin
			snap <= map;
		end
	end

endmodule

// ==== design/score_board.sv ====
`timescale 1ns/1ps

module score_board (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          update,
	input  logic                          draw,
	input  logic [score_pkg::GROUND_W-1:0] ground,
	input  logic [score_pkg::POS_W-1:0]    mouse_position,
	output logic [score_pkg::X_W-1:0]      x,
	output logic [score_pkg::Y_W-1:0]      y,
	output logic [score_pkg::COLOR_W-1:0]  color,
	output logic                          plot,
	output logic                          finish_drawing,
	output logic                          finish_game,
	output logic [score_pkg::SCORE_W-1:0]  score,
	output logic [score_pkg::LIVES_W-1:0]  lives
);
	import score_pkg::*;

	logic [CNT_W-1:0]   good_count;
	logic [CNT_W-1:0]   bad_count;
	logic               catch_valid;
	logic [DIGIT_W-1:0] tens;
	logic [DIGIT_W-1:0] ones;
	logic [MAP_W-1:0]   map;

	catch_detect i_catch_detect (
		.clk, .reset, .update, .ground, .mouse_position,
		.good_count, .bad_count, .catch_valid
	);

	score_tally i_score_tally (
		.clk, .reset, .good_count, .bad_count, .catch_valid,
		.score, .lives, .finish_game
	);

	digit_split i_digit_split (.clk, .reset, .score, .tens, .ones);

	glyph_map i_glyph_map (.clk, .reset, .tens, .ones, .map);

	score_painter i_score_painter (
		.clk, .reset, .draw, .map,
		.x, .y, .color, .plot, .finish_drawing
	);

endmodule

// ==== bench/score_board_properties.sv ====
`timescale 1ns/1ps

module score_board_properties (
	input logic                          clk,
	input logic                          reset,
	input logic                          plot,
	input logic                          finish_drawing,
	input logic                          finish_game,
	input logic [score_pkg::LIVES_W-1:0] lives
);

	int error_count = 0; // Failed assertion attempts

	no_plot_when_done: assert property (@(posedge clk) disable iff (!reset)
		!(plot && finish_drawing))
		else begin
			$error("plot was high while finish_drawing was high");
			error_count++;
		end

	game_over_holds: assert property (@(posedge clk) disable iff (!reset)
		finish_game |=> finish_game)
		else begin
			$error("finish_game fell without a reset");
			error_count++;
		end

	lives_never_rise: assert property (@(posedge clk) disable iff (!reset)
		lives <= $past(lives))
		else begin
			$error("lives increased outside of reset");
			error_count++;
		end

endmodule

bind score_board score_board_properties i_properties (
	.clk, .reset, .plot, .finish_drawing, .finish_game, .lives
);

// ==== bench/score_board_tb.sv ====
`timescale 1ns/1ps

module score_board_tb;
	import score_pkg::*;

	typedef struct packed {
		logic                reset_first;
		logic                paint;
		logic [GROUND_W-1:0] ground;
		logic [POS_W-1:0]    pos;
		logic [SCORE_W-1:0]  score;
		logic [LIVES_W-1:0]  lives;
	} row_t;

	logic                clk;
	logic                reset;
	logic                update;
	logic                draw;
	logic [GROUND_W-1:0] ground;
	logic [POS_W-1:0]    mouse_position;
	logic [X_W-1:0]      x;
	logic [Y_W-1:0]      y;
	logic [COLOR_W-1:0]  color;
	logic                plot;
	logic                finish_drawing;
	logic                finish_game;
	logic [SCORE_W-1:0]  score;
	logic [LIVES_W-1:0]  lives;

	// Rows top to bottom, left column first
	string font [10] = '{
		"####.##.##.####", ".#.##..#..#.###", "###..#####..###", "###..####..####",
		"#.##.####..#..#", "####..###..####", "####..####.####", "###..#..#..#..#",
		"####.#####.####", "####.####..####"
	};

	row_t rows [$];
	int   mismatch_count;
	int   failure_count;
	int   max_wait = 100;

	score_board i_dut (
		.clk, .reset, .update, .draw, .ground, .mouse_position,
		.x, .y, .color, .plot, .finish_drawing, .finish_game, .score, .lives
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [GROUND_W-1:0] cell_bits(input int idx, input logic [1:0] code);
		logic [GROUND_W-1:0] g;
		g = '0;
		g[GROUND_W - 2 - 2 * idx +: 2] = code; // Cell 0 sits in the top bits
		return g;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		assert (actual === expected) else begin
			mismatch_count++;
			$display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset = 1'b0;
		update = 1'b0;
		draw = 1'b0;
		repeat (3) @(negedge clk);
		reset = 1'b1;
		check_value("score", score, 0);
		check_value("lives", lives, 3);
		check_value("finish_game", finish_game, 0);
		check_value("plot", plot, 0);
		check_value("finish_drawing", finish_drawing, 0);
		check_value("x", x, 0);
		check_value("y", y, 0);
		check_value("color", color, 0);
	endtask

	task automatic send_update(input row_t r);
		ground = r.ground;
		mouse_position = r.pos;
		update = 1'b1;
		@(negedge clk);
		update = 1'b0;
		repeat (4) @(negedge clk); // Score and map have settled by now
	endtask

	task automatic paint_and_check(input int value);
		int digits [2];
		int wait_cycles;
		int d;
		int i;
		logic [COLOR_W-1:0] exp_color;
		digits[0] = value / 10;
		digits[1] = value % 10;
		draw = 1'b1;
		wait_cycles = 0;
		while (!plot && wait_cycles < max_wait) begin
			@(negedge clk);
			wait_cycles++;
		end
		assert (plot) else begin
			failure_count++;
			$display("Timeout at %0t: no pixel was plotted after draw went high", $time);
		end
		for (int p = 0; p < 30; p++) begin
			d = p / 15;
			i = p % 15;
			exp_color = (font[digits[d]][i] == "#") ? COLOR_INK : COLOR_BLANK;
			check_value("plot", plot, 1);
			check_value("x", x, SCORE_X + d * DIGIT_PITCH + i % 3);
			check_value("y", y, SCORE_Y + i / 3);
			check_value("color", color, exp_color);
			@(negedge clk);
		end
		wait_cycles = 0;
		while (!finish_drawing && wait_cycles < max_wait) begin
			check_value("plot", plot, 0); // A 31st pixel would show here
			@(negedge clk);
			wait_cycles++;
		end
		assert (finish_drawing) else begin
			failure_count++;
			$display("Timeout at %0t: finish_drawing never rose after the last pixel", $time);
		end
		repeat (3) begin
			check_value("finish_drawing", finish_drawing, 1);
			check_value("plot", plot, 0);
			@(negedge clk);
		end
		draw = 1'b0;
		@(negedge clk);
		check_value("finish_drawing", finish_drawing, 0);
	endtask

	task automatic build_table();
		logic [GROUND_W-1:0] g;
		int sat;
		// Window edges at both ends of the row and the clamp past cell 29
		g = cell_bits(0, CELL_GOOD) | cell_bits(1, CELL_GOOD) | cell_bits(2, CELL_GOOD);
		rows.push_back('{1'b0, 1'b0, g, 9'd0, 7'd2, 2'd3});
		g = cell_bits(0, CELL_GOOD) | cell_bits(2, CELL_GOOD) | cell_bits(3, CELL_BAD);
		rows.push_back('{1'b0, 1'b0, g, 9'd5, 7'd4, 2'd3});
		g = cell_bits(26, CELL_BAD) | cell_bits(27, CELL_GOOD) | cell_bits(28, 2'd1)
			| cell_bits(29, CELL_GOOD);
		rows.push_back('{1'b0, 1'b0, g, 9'd115, 7'd6, 2'd3});
		g = cell_bits(27, CELL_GOOD) | cell_bits(28, CELL_GOOD) | cell_bits(29, CELL_BAD);
		rows.push_back('{1'b0, 1'b0, g, 9'd116, 7'd7, 2'd2});
		g = cell_bits(27, CELL_GOOD) | cell_bits(28, CELL_GOOD) | cell_bits(29, CELL_GOOD);
		rows.push_back('{1'b0, 1'b1, g, 9'd300, 7'd9, 2'd2});
		// Three good cells per update until the score pins at 99
		g = cell_bits(8, CELL_BAD) | cell_bits(9, CELL_GOOD) | cell_bits(10, CELL_GOOD)
			| cell_bits(11, CELL_GOOD) | cell_bits(12, CELL_BAD);
		for (int k = 1; k <= 31; k++) begin
			sat = 9 + 3 * k;
			if (sat > 99) begin
				sat = 99;
			end
			rows.push_back('{1'b0, k == 16, g, 9'd40, 7'(sat), 2'd2});
		end
		g = cell_bits(9, CELL_GOOD) | cell_bits(10, CELL_BAD);
		rows.push_back('{1'b1, 1'b0, g, 9'd40, 7'd1, 2'd2});
		g = cell_bits(9, CELL_BAD) | cell_bits(10, CELL_BAD) | cell_bits(11, CELL_GOOD);
		rows.push_back('{1'b0, 1'b0, g, 9'd40, 7'd2, 2'd0});
		g = cell_bits(9, CELL_GOOD) | cell_bits(10, CELL_GOOD) | cell_bits(11, CELL_BAD);
		rows.push_back('{1'b0, 1'b0, g, 9'd40, 7'd2, 2'd0}); // Frozen after game over
		g = cell_bits(9, CELL_GOOD) | cell_bits(10, CELL_GOOD) | cell_bits(11, CELL_GOOD);
		rows.push_back('{1'b0, 1'b0, g, 9'd40, 7'd2, 2'd0});
	endtask

	initial begin
		reset = 1'b0;
		update = 1'b0;
		draw = 1'b0;
		ground = '0;
		mouse_position = '0;
		mismatch_count = 0;
		failure_count = 0;
		build_table();
		apply_reset();
		foreach (rows[n]) begin
			if (rows[n].reset_first) begin
				apply_reset();
			end
			send_update(rows[n]);
			check_value("score", score, rows[n].score);
			check_value("lives", lives, rows[n].lives);
			check_value("finish_game", finish_game, rows[n].lives == 0);
			if (rows[n].paint) begin
				paint_and_check(rows[n].score);
			end
		end
		$display("Error count: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatch_count, failure_count, i_dut.i_properties.error_count);
		if (mismatch_count == 0 && failure_count == 0
				&& i_dut.i_properties.error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== src.f ====
design/score_pkg.sv
design/catch_detect.sv
design/score_tally.sv
design/digit_split.sv
design/glyph_map.sv
design/score_painter.sv
design/score_board.sv
bench/score_board_properties.sv
bench/score_board_tb.sv

// ==== Bender.yml ====
package:
  name: score_board

sources:
  - design/score_pkg.sv
  - design/catch_detect.sv
  - design/score_tally.sv
  - design/digit_split.sv
  - design/glyph_map.sv
  - design/score_painter.sv
  - design/score_board.sv
  - target: simulation
    files:
      - bench/score_board_properties.sv
      - bench/score_board_tb.sv
